//--- rtl/cmd_macros.svh
// constants for the 8-byte USB command path; response is always one 32-bit beat
`ifndef CMD_MACROS_SVH
`define CMD_MACROS_SVH

// command framing
`define CMD_BYTES 8 // bytes per command
`define RESP_WIDTH 32 // one response beat

// readback value for version queries
`define FW_VERSION 26

// threshold conversion from 8-bit center/width to 12-bit ADC scale
`define THRESH_OFFSET 128 // mid-scale of the 8-bit input
`define THRESH_SHIFT 4 // 8 to 12 bit scaling
`define THRESH_ROUND 8 // half an lsb of the 8-bit scale

// fixed acknowledge codes
`define RESP_TRIG_ACK 8 // trigger settings stored
`define RESP_DS_ACK 9 // downsample settings stored

`endif

//--- rtl/cmd_pkg.sv
// command and response types; byte 0 of a command is the first byte received
`include "cmd_macros.svh"

package cmd_pkg;

   typedef enum logic [7:0] {
      OP_ARM      = 8'd1,  // arm trigger, set length to take
      OP_HK       = 8'd2,  // housekeeping, see hk_sel_e
      OP_TRIG     = 8'd8,  // trigger thresholds
      OP_DS       = 8'd9,  // downsampling
      OP_BOARDOUT = 8'd10,
      OP_STATUS   = 8'd12,
      OP_READREG  = 8'd14  // register readback, see reg_sel_e
   } cmd_opcode_e;

   typedef enum logic [7:0] {
      HK_VERSION      = 8'd0,
      HK_BOARDIN      = 8'd1,
      HK_EVENTCOUNTER = 8'd3,
      HK_FAN          = 8'd6,
      HK_PRELENGTH    = 8'd7,
      HK_ROLLING      = 8'd8
   } hk_sel_e;

   typedef enum logic [7:0] {
      REG_PREOFFSET    = 8'd0,
      REG_VERSION      = 8'd3,
      REG_BOARDIN      = 8'd4,
      REG_ACQSTATE     = 8'd5,
      REG_EVENTCOUNTER = 8'd6,
      REG_SAMPLE_TRIG  = 8'd7,
      REG_MERGING      = 8'd9,
      REG_DOWNSAMPLE   = 8'd10,
      REG_HIGHRES      = 8'd11,
      REG_UPPERTHRESH  = 8'd12
   } reg_sel_e;

   // listed from byte 7 down to byte 0 so it overlays the byte view
   typedef struct packed {
      logic [7:0] pad;        // byte 7
      logic [7:0] chan;       // byte 6, bit 0 used
      logic [7:0] tot;        // byte 5
      logic [7:0] preoff_lo;  // byte 4
      logic [7:0] preoff_hi;  // byte 3, bits 1:0 used
      logic [7:0] half_width; // byte 2
      logic [7:0] center;     // byte 1
      logic [7:0] opcode;     // byte 0
   } trig_cmd_t;

   typedef union packed {
      logic [`CMD_BYTES-1:0][7:0] bytes; // bytes[0] arrives first
      trig_cmd_t                  trig;
   } cmd_word_u;

   typedef logic [`RESP_WIDTH-1:0] resp_word_t;

   typedef logic signed [11:0] thresh_t;

endpackage

//--- rtl/cmd_rx_assembler.sv
// collects eight stream bytes; stalls the stream while a full command waits on tx_busy
`include "cmd_macros.svh"

module cmd_rx_assembler (
   input  logic              clk50,
   input  logic              pllreset2,
   input  logic              i_tvalid,
   input  logic [7:0]        i_tdata,
   input  logic              i_tx_busy,
   output logic              o_tready,
   output logic              o_cmd_strobe,
   output cmd_pkg::cmd_word_u o_cmd_word
);

   localparam int CNT_W = $clog2(`CMD_BYTES);

   logic [CNT_W-1:0] byte_cnt;
   logic             full; // complete command not yet passed on
   logic             take;

   assign o_tready = !full;
   assign take     = i_tvalid && o_tready;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         byte_cnt     <= '0;
         full         <= 1'b0;
         o_cmd_strobe <= 1'b0;
      end else begin
         o_cmd_strobe <= 1'b0;
         if (full) begin
            if (!i_tx_busy) begin // previous response gone
               o_cmd_strobe <= 1'b1;
               full         <= 1'b0;
            end
         end else if (take) begin
            if (byte_cnt == CNT_W'(`CMD_BYTES - 1)) full <= 1'b1;
            byte_cnt <= byte_cnt + 1'b1; // wraps to 0 after last byte
         end
      end
   end

   always_ff @(posedge clk50) begin
      if (take) o_cmd_word.bytes[byte_cnt] <= i_tdata; // arrival order
   end

   // the transmitter must be free whenever a command goes downstream
   a_strobe_not_busy : assert property (@(posedge clk50) disable iff (pllreset2)
      o_cmd_strobe |-> !i_tx_busy);

endmodule

//--- rtl/cmd_executor.sv
// decodes one command per strobe; unknown opcodes give no response, status inputs sampled once
`include "cmd_macros.svh"

module cmd_executor (
   input  logic               clk50,
   input  logic               pllreset2,
   input  logic               i_cmd_strobe,
   input  cmd_pkg::cmd_word_u i_cmd_word,
   input  logic [7:0]         i_acqstate,
   input  logic [31:0]        i_eventcounter,
   input  logic [19:0]        i_sample_triggered,
   input  logic [7:0]         i_boardin,
   output logic               o_resp_strobe,
   output cmd_pkg::resp_word_t o_resp_word,
   output cmd_pkg::thresh_t   o_lowerthresh,
   output cmd_pkg::thresh_t   o_upperthresh,
   output logic [15:0]        o_lengthtotake,
   output logic [15:0]        o_prelengthtotake,
   output logic               o_trigger_arm,
   output logic [7:0]         o_triggertype,
   output logic [7:0]         o_triggertot,
   output logic               o_triggerchan,
   output logic [7:0]         o_channeltype,
   output logic               o_dorolling,
   output logic [4:0]         o_downsample,
   output logic               o_highres,
   output logic [7:0]         o_downsamplemerging,
   output logic [7:0]         o_boardout,
   output logic               o_fanon
);

   logic [7:0]  acqstate_q;
   logic [31:0] eventcounter_q;
   logic [19:0] sample_trig_q;
   logic [7:0]  boardin_q;
   logic [9:0]  preoffset;
   logic [7:0]  opcode;
   logic [7:0]  sel; // subselect / register number in byte 1
   logic        cmd_known;
   logic [7:0]  boardout_nxt;
   logic [11:0] center12, hw12;
   cmd_pkg::thresh_t   lower_nxt, upper_nxt;
   cmd_pkg::resp_word_t resp_nxt, status_word;

   assign opcode      = i_cmd_word.trig.opcode;
   assign sel         = i_cmd_word.bytes[1];
   assign center12    = {4'd0, i_cmd_word.trig.center};
   assign hw12        = {4'd0, i_cmd_word.trig.half_width};
   assign lower_nxt   = ((center12 - hw12 - 12'(`THRESH_OFFSET)) << `THRESH_SHIFT)
                        + 12'(`THRESH_ROUND);
   assign upper_nxt   = ((center12 + hw12 - 12'(`THRESH_OFFSET)) << `THRESH_SHIFT)
                        + 12'(`THRESH_ROUND);
   assign status_word = {4'd0, sample_trig_q, acqstate_q};

   always_comb begin
      boardout_nxt = o_boardout;
      boardout_nxt[i_cmd_word.bytes[1][2:0]] = i_cmd_word.bytes[2][0];
   end

   always_comb begin
      cmd_known = 1'b1;
      resp_nxt  = '0;
      case (opcode)
         cmd_pkg::OP_ARM, cmd_pkg::OP_STATUS: resp_nxt = status_word;
         cmd_pkg::OP_HK: begin
            case (sel)
               cmd_pkg::HK_VERSION:      resp_nxt = 32'(`FW_VERSION);
               cmd_pkg::HK_BOARDIN:      resp_nxt = {24'd0, boardin_q};
               cmd_pkg::HK_EVENTCOUNTER: resp_nxt = eventcounter_q;
               cmd_pkg::HK_FAN:          resp_nxt = {31'd0, o_fanon}; // value before update
               cmd_pkg::HK_PRELENGTH:    resp_nxt = {16'd0, o_prelengthtotake};
               cmd_pkg::HK_ROLLING:      resp_nxt = {31'd0, o_dorolling};
               default:                  resp_nxt = '0;
            endcase
         end
         cmd_pkg::OP_TRIG:     resp_nxt = 32'(`RESP_TRIG_ACK);
         cmd_pkg::OP_DS:       resp_nxt = 32'(`RESP_DS_ACK);
         cmd_pkg::OP_BOARDOUT: resp_nxt = {24'd0, boardout_nxt}; // new value
         cmd_pkg::OP_READREG: begin
            case (sel)
               cmd_pkg::REG_PREOFFSET:    resp_nxt = {22'd0, preoffset};
               cmd_pkg::REG_VERSION:      resp_nxt = 32'(`FW_VERSION);
               cmd_pkg::REG_BOARDIN:      resp_nxt = {24'd0, boardin_q};
               cmd_pkg::REG_ACQSTATE:     resp_nxt = {24'd0, acqstate_q};
               cmd_pkg::REG_EVENTCOUNTER: resp_nxt = eventcounter_q;
               cmd_pkg::REG_SAMPLE_TRIG:  resp_nxt = {12'd0, sample_trig_q};
               cmd_pkg::REG_MERGING:      resp_nxt = {24'd0, o_downsamplemerging};
               cmd_pkg::REG_DOWNSAMPLE:   resp_nxt = {27'd0, o_downsample};
               cmd_pkg::REG_HIGHRES:      resp_nxt = {31'd0, o_highres};
               cmd_pkg::REG_UPPERTHRESH:  resp_nxt = {20'd0, o_upperthresh};
               default:                   resp_nxt = '0;
            endcase
         end
         default: cmd_known = 1'b0; // dropped silently
      endcase
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_resp_strobe       <= 1'b0;
         o_trigger_arm       <= 1'b0;
         o_lowerthresh       <= '0;
         o_upperthresh       <= '0;
         o_lengthtotake      <= '0;
         o_prelengthtotake   <= '0;
         o_triggertype       <= '0;
         o_triggertot        <= '0;
         o_triggerchan       <= 1'b0;
         o_channeltype       <= '0;
         o_dorolling         <= 1'b0;
         o_downsample        <= '0;
         o_highres           <= 1'b0;
         o_downsamplemerging <= '0;
         o_boardout          <= '0;
         o_fanon             <= 1'b0;
         preoffset           <= '0;
      end else begin
         o_resp_strobe <= i_cmd_strobe && cmd_known;
         o_trigger_arm <= 1'b0; // single-cycle pulse
         if (i_cmd_strobe) begin
            case (opcode)
               cmd_pkg::OP_ARM: begin
                  o_triggertype  <= i_cmd_word.bytes[1];
                  o_channeltype  <= i_cmd_word.bytes[2];
                  o_lengthtotake <= {i_cmd_word.bytes[5], i_cmd_word.bytes[4]};
                  o_trigger_arm  <= (acqstate_q == 8'd0); // only when idle
               end
               cmd_pkg::OP_HK: begin
                  case (sel)
                     cmd_pkg::HK_FAN:       o_fanon <= i_cmd_word.bytes[2][0];
                     cmd_pkg::HK_PRELENGTH: o_prelengthtotake <= {i_cmd_word.bytes[3],
                                                                 i_cmd_word.bytes[2]};
                     cmd_pkg::HK_ROLLING:   o_dorolling <= i_cmd_word.bytes[2][0];
                     default: ;
                  endcase
               end
               cmd_pkg::OP_TRIG: begin
                  o_lowerthresh <= lower_nxt;
                  o_upperthresh <= upper_nxt;
                  preoffset     <= {i_cmd_word.trig.preoff_hi[1:0], i_cmd_word.trig.preoff_lo};
                  o_triggertot  <= i_cmd_word.trig.tot;
                  o_triggerchan <= i_cmd_word.trig.chan[0];
               end
               cmd_pkg::OP_DS: begin
                  o_downsample        <= i_cmd_word.bytes[1][4:0];
                  o_highres           <= i_cmd_word.bytes[2][0];
                  o_downsamplemerging <= i_cmd_word.bytes[3];
               end
               cmd_pkg::OP_BOARDOUT: o_boardout <= boardout_nxt;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk50) begin
      acqstate_q     <= i_acqstate; // status inputs registered once
      eventcounter_q <= i_eventcounter;
      sample_trig_q  <= i_sample_triggered;
      boardin_q      <= i_boardin;
      if (i_cmd_strobe) o_resp_word <= resp_nxt;
   end

   // an arm pulse comes with the response that reports an idle acquisition
   a_arm_when_idle : assert property (@(posedge clk50) disable iff (pllreset2)
      o_trigger_arm |-> o_resp_strobe && o_resp_word[7:0] == 8'd0);

endmodule

//--- rtl/usb_resp_tx.sv
// holds a single response beat; a new strobe is only legal while not busy
`include "cmd_macros.svh"

module usb_resp_tx (
   input  logic                      clk50,
   input  logic                      pllreset2,
   input  logic                      i_resp_strobe,
   input  cmd_pkg::resp_word_t       i_resp_word,
   input  logic                      i_tready,
   output logic                      o_tvalid,
   output cmd_pkg::resp_word_t       o_tdata,
   output logic [`RESP_WIDTH/8-1:0]  o_tkeep,
   output logic                      o_tlast,
   output logic                      o_tx_busy
);

   logic held; // response waiting for the host

   assign o_tvalid  = held;
   assign o_tx_busy = held;
   assign o_tkeep   = '1; // every response is a full word
   assign o_tlast   = 1'b1; // and a single beat

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         held <= 1'b0;
      end else begin
         if (held && i_tready) held <= 1'b0; // beat taken
         if (i_resp_strobe) held <= 1'b1;
      end
   end

   always_ff @(posedge clk50) begin
      if (i_resp_strobe) o_tdata <= i_resp_word;
   end

   // data must not move under a stalled beat
   a_data_stable : assert property (@(posedge clk50) disable iff (pllreset2)
      o_tvalid && !i_tready |=> $stable(o_tdata));

endmodule

//--- rtl/command_processor.sv
// USB command path top; one 4-byte response per known command, no RAM readout
`include "cmd_macros.svh"

module command_processor (
   input  logic                     clk50,
   input  logic                     pllreset2,
   input  logic                     i_tvalid,
   input  logic [7:0]               i_tdata,
   output logic                     o_tready,
   output logic                     o_tvalid,
   output cmd_pkg::resp_word_t      o_tdata,
   output logic [`RESP_WIDTH/8-1:0] o_tkeep,
   output logic                     o_tlast,
   input  logic                     i_tready,
   input  logic [7:0]               i_acqstate,
   input  logic [31:0]              i_eventcounter,
   input  logic [19:0]              i_sample_triggered,
   input  logic [7:0]               i_boardin,
   output cmd_pkg::thresh_t         o_lowerthresh,
   output cmd_pkg::thresh_t         o_upperthresh,
   output logic [15:0]              o_lengthtotake,
   output logic [15:0]              o_prelengthtotake,
   output logic                     o_trigger_arm,
   output logic [7:0]               o_triggertype,
   output logic [7:0]               o_triggertot,
   output logic                     o_triggerchan,
   output logic [7:0]               o_channeltype,
   output logic                     o_dorolling,
   output logic [4:0]               o_downsample,
   output logic                     o_highres,
   output logic [7:0]               o_downsamplemerging,
   output logic [7:0]               o_boardout,
   output logic                     o_fanon
);

   logic                cmd_strobe;
   cmd_pkg::cmd_word_u  cmd_word;
   logic                resp_strobe;
   cmd_pkg::resp_word_t resp_word;
   logic                tx_busy; // response still held by the transmitter

   cmd_rx_assembler u_rx (
      .clk50(clk50), .pllreset2(pllreset2), .i_tvalid(i_tvalid), .i_tdata(i_tdata),
      .i_tx_busy(tx_busy), .o_tready(o_tready), .o_cmd_strobe(cmd_strobe),
      .o_cmd_word(cmd_word));

   cmd_executor u_exec (
      .clk50(clk50), .pllreset2(pllreset2), .i_cmd_strobe(cmd_strobe),
      .i_cmd_word(cmd_word), .i_acqstate(i_acqstate), .i_eventcounter(i_eventcounter),
      .i_sample_triggered(i_sample_triggered), .i_boardin(i_boardin),
      .o_resp_strobe(resp_strobe), .o_resp_word(resp_word),
      .o_lowerthresh(o_lowerthresh), .o_upperthresh(o_upperthresh),
      .o_lengthtotake(o_lengthtotake), .o_prelengthtotake(o_prelengthtotake),
      .o_trigger_arm(o_trigger_arm), .o_triggertype(o_triggertype),
      .o_triggertot(o_triggertot), .o_triggerchan(o_triggerchan),
      .o_channeltype(o_channeltype), .o_dorolling(o_dorolling),
      .o_downsample(o_downsample), .o_highres(o_highres),
      .o_downsamplemerging(o_downsamplemerging), .o_boardout(o_boardout),
      .o_fanon(o_fanon));

   usb_resp_tx u_tx (
      .clk50(clk50), .pllreset2(pllreset2), .i_resp_strobe(resp_strobe),
      .i_resp_word(resp_word), .i_tready(i_tready), .o_tvalid(o_tvalid),
      .o_tdata(o_tdata), .o_tkeep(o_tkeep), .o_tlast(o_tlast), .o_tx_busy(tx_busy));

endmodule

//--- verif/tb_command_processor.sv
// needs verif/cmd_stim.txt relative to the run directory; stops at the first mismatch
`include "cmd_macros.svh"

module tb_command_processor;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int TIMEOUT_CYC = 400;

   typedef struct packed {
      logic [127:0]        name;
      cmd_pkg::resp_word_t resp;
      cmd_pkg::thresh_t    lower;
      cmd_pkg::thresh_t    upper;
      logic [31:0]         arms; // arm pulses seen so far
      logic [31:0]         cfg;  // {triggertype, channeltype, lengthtotake}
      logic [31:0]         misc; // {boardout, merging, downsample, highres/rolling/fan}
      logic [7:0]          tot;  // time-over-threshold of the last trigger command
      logic                chan;
      logic [15:0]         prelen;
   } expect_t;

   logic                     clk50;
   logic                     pllreset2;
   logic                     i_tvalid;
   logic [7:0]               i_tdata;
   logic                     o_tready;
   logic                     o_tvalid;
   cmd_pkg::resp_word_t      o_tdata;
   logic [`RESP_WIDTH/8-1:0] o_tkeep;
   logic                     o_tlast;
   logic                     i_tready;
   logic [7:0]               i_acqstate;
   logic [31:0]              i_eventcounter;
   logic [19:0]              i_sample_triggered;
   logic [7:0]               i_boardin;
   cmd_pkg::thresh_t         o_lowerthresh;
   cmd_pkg::thresh_t         o_upperthresh;
   logic [15:0]              o_lengthtotake;
   logic [15:0]              o_prelengthtotake;
   logic                     o_trigger_arm;
   logic [7:0]               o_triggertype;
   logic [7:0]               o_triggertot;
   logic                     o_triggerchan;
   logic [7:0]               o_channeltype;
   logic                     o_dorolling;
   logic [4:0]               o_downsample;
   logic                     o_highres;
   logic [7:0]               o_downsamplemerging;
   logic [7:0]               o_boardout;
   logic                     o_fanon;

   integer  seed = 32'h92257b50;
   logic    ready_draw;
   logic    lat_mode; // host always ready during the latency check
   int      arm_cnt;
   expect_t exp_q[$];

   command_processor i_dut (.*);

   initial begin
      clk50 = 1'b0;
      forever #4 clk50 = ~clk50;
   end

   always @(negedge clk50) ready_draw = (($random(seed) & 3) != 0); // ready ~3 of 4 cycles

   always @(posedge clk50) begin
      if (pllreset2 || lat_mode) i_tready <= 1'b1;
      else i_tready <= ready_draw;
   end

   task automatic stop_on_error(input string msg);
      $display("%0s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_resp(input logic [127:0] name, input string what,
                             input cmd_pkg::resp_word_t exp, input cmd_pkg::resp_word_t act);
      if (act !== exp)
         stop_on_error($sformatf("[FAIL] %0s %0s: expected %h, got %h", name, what, exp, act));
   endtask

   task automatic check_thresh(input logic [127:0] name, input string what,
                               input cmd_pkg::thresh_t exp, input cmd_pkg::thresh_t act);
      if (act !== exp)
         stop_on_error($sformatf("[FAIL] %0s %0s: expected %0d, got %0d", name, what, exp, act));
   endtask

   task automatic check_bit(input logic [127:0] name, input string what,
                            input logic exp, input logic act);
      if (act !== exp)
         stop_on_error($sformatf("[FAIL] %0s %0s: expected %b, got %b", name, what, exp, act));
   endtask

   task automatic check_word(input logic [127:0] name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp)
         stop_on_error($sformatf("[FAIL] %0s %0s: expected %h, got %h", name, what, exp, act));
   endtask

   // called one half cycle before the beat completes, outputs are settled here
   task automatic match_beat();
      expect_t e;
      if (exp_q.size() == 0) begin
         stop_on_error("a response beat arrived with no command outstanding");
      end else begin
         e = exp_q.pop_front();
         check_resp(e.name, "o_tdata", e.resp, o_tdata);
         check_bit(e.name, "o_tkeep all ones", 1'b1, &o_tkeep);
         check_bit(e.name, "o_tlast", 1'b1, o_tlast);
         check_thresh(e.name, "o_lowerthresh", e.lower, o_lowerthresh);
         check_thresh(e.name, "o_upperthresh", e.upper, o_upperthresh);
         check_word(e.name, "arm pulses", e.arms, 32'(arm_cnt));
         check_word(e.name, "arm config", e.cfg, {o_triggertype, o_channeltype, o_lengthtotake});
         check_word(e.name, "misc outputs", e.misc, {o_boardout, o_downsamplemerging, 3'd0,
                    o_downsample, 5'd0, o_highres, o_dorolling, o_fanon});
         check_word(e.name, "o_triggertot", 32'(e.tot), 32'(o_triggertot));
         check_bit(e.name, "o_triggerchan", e.chan, o_triggerchan);
         check_word(e.name, "o_prelengthtotake", 32'(e.prelen), 32'(o_prelengthtotake));
      end
   endtask

   always @(negedge clk50) begin
      if (!pllreset2) begin
         if (o_trigger_arm) arm_cnt = arm_cnt + 1;
         if (o_tvalid && i_tready) match_beat();
      end
   end

   // starts right after a rising edge, returns right after the edge that took byte 7
   task automatic send_cmd(input cmd_pkg::cmd_word_u w, input bit no_gap);
      int   i;
      int   gap;
      int   t;
      logic rdy;
      for (i = 0; i < `CMD_BYTES; i++) begin
         gap = no_gap ? 0 : ($random(seed) & 3);
         if (gap != 0) begin
            i_tvalid <= 1'b0; // idle gap
            repeat (gap) @(posedge clk50);
         end
         i_tvalid <= 1'b1;
         i_tdata  <= w.bytes[i];
         t = 0;
         rdy = 1'b0;
         while (!rdy) begin
            @(negedge clk50);
            rdy = o_tready; // holds until the next rising edge
            @(posedge clk50);
            t = t + 1;
            if (t > TIMEOUT_CYC) stop_on_error("timeout waiting for the DUT to take a byte");
         end
      end
      i_tvalid <= 1'b0;
   endtask

   task automatic drain_responses();
      int t;
      t = 0;
      do begin
         @(negedge clk50);
         t = t + 1;
         if (t > TIMEOUT_CYC) stop_on_error("timeout waiting for outstanding responses");
      end while (exp_q.size() != 0 || o_tvalid);
   endtask

   initial begin
      int                 fd;
      int                 n;
      int                 i;
      int                 mode; // 0 no response, 1 response, 2 response and latency check
      int                 arms_line;
      int                 arm_total;
      string              line;
      logic [127:0]       name;
      logic [7:0]         b [8];
      logic [7:0]         acq;
      logic [7:0]         bin;
      logic [31:0]        evc;
      logic [19:0]        strig;
      cmd_pkg::resp_word_t resp;
      cmd_pkg::thresh_t   lower;
      cmd_pkg::thresh_t   upper;
      logic [31:0]        cfg;
      logic [31:0]        misc;
      logic [7:0]         tot_model;
      logic               chan_model;
      logic [15:0]        prelen_model;
      cmd_pkg::cmd_word_u w;
      expect_t            e;
      pllreset2          = 1'b1;
      i_tvalid           = 1'b0;
      i_tdata            = 8'd0;
      i_tready           = 1'b1;
      i_acqstate         = 8'd0;
      i_eventcounter     = 32'd0;
      i_sample_triggered = 20'd0;
      i_boardin          = 8'd0;
      lat_mode           = 1'b0;
      arm_cnt            = 0;
      arm_total          = 0;
      tot_model          = 8'd0;
      chan_model         = 1'b0;
      prelen_model       = 16'd0;
      repeat (2) @(posedge clk50);
      pllreset2 <= 1'b0;
      @(negedge clk50);
      check_bit("reset", "o_tvalid", 1'b0, o_tvalid);
      check_bit("reset", "o_trigger_arm", 1'b0, o_trigger_arm);
      check_bit("reset", "o_fanon", 1'b0, o_fanon);
      check_bit("reset", "o_dorolling", 1'b0, o_dorolling);
      check_bit("reset", "o_tready", 1'b1, o_tready);
      fd = $fopen("verif/cmd_stim.txt", "r");
      if (fd == 0) stop_on_error("cannot open the stimulus file verif/cmd_stim.txt");
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %d %h %h",
                        name, b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7],
                        acq, evc, strig, bin, mode, resp, lower, upper, arms_line, cfg, misc);
            if (n != 20) stop_on_error($sformatf("malformed stimulus line: %0s", line));
            // status is sampled at execution, so let queued commands finish first
            if ({acq, evc, strig, bin} !== {i_acqstate, i_eventcounter, i_sample_triggered,
                                             i_boardin}) drain_responses();
            if (mode == 2) begin
               lat_mode = 1'b1;
               drain_responses();
            end
            for (i = 0; i < `CMD_BYTES; i++) w.bytes[i] = b[i];
            if (b[0] == cmd_pkg::OP_TRIG) begin
               tot_model  = b[5]; // byte 5 of the trigger settings
               chan_model = b[6][0];
            end
            if (b[0] == cmd_pkg::OP_HK && b[1] == cmd_pkg::HK_PRELENGTH)
               prelen_model = {b[3], b[2]};
            @(posedge clk50);
            i_acqstate         <= acq;
            i_eventcounter     <= evc;
            i_sample_triggered <= strig;
            i_boardin          <= bin;
            send_cmd(w, mode == 2);
            arm_total = arm_total + arms_line;
            if (mode != 0) begin
               e.name   = name;
               e.resp   = resp;
               e.lower  = lower;
               e.upper  = upper;
               e.arms   = 32'(arm_total);
               e.cfg    = cfg;
               e.misc   = misc;
               e.tot    = tot_model;
               e.chan   = chan_model;
               e.prelen = prelen_model;
               exp_q.push_back(e);
            end
            if (mode == 2) begin
               repeat (3) begin
                  @(negedge clk50);
                  check_bit(name, "o_tvalid before latency", 1'b0, o_tvalid);
               end
               @(negedge clk50);
               check_bit(name, "o_tvalid three cycles after last byte", 1'b1, o_tvalid);
               lat_mode = 1'b0;
            end
         end
      end
      $fclose(fd);
      drain_responses();
      $display("Everything OK");
      $finish;
   end

endmodule

//--- verif/cmd_stim.txt
# name b0..b7 acq evcnt strig boardin mode resp lower upper arms cfg misc (hex, mode/arms dec)
# mode 0=no resp 1=resp 2=resp+latency; cfg={ttype,chtype,len} misc={bout,merge,ds,hr,roll,fan}
arm_idle 01 05 02 00 34 12 00 00 00 00000000 12345 00 1 01234500 000 000 1 05021234 00000000
arm_busy 01 07 03 00 00 01 00 00 03 00000000 00abc 00 1 000abc03 000 000 0 07030100 00000000
status 0c 00 00 00 00 00 00 00 05 00000000 fffff 00 1 0fffff05 000 000 0 07030100 00000000
trig_pos 08 c0 10 02 34 55 01 00 05 00000000 fffff 00 1 00000008 308 508 0 07030100 00000000
rd_upper 0e 0c 00 00 00 00 00 00 05 00000000 fffff 00 1 00000508 308 508 0 07030100 00000000
rd_preoff 0e 00 00 00 00 00 00 00 05 00000000 fffff 00 1 00000234 308 508 0 07030100 00000000
trig_neg 08 40 10 00 00 00 00 00 05 00000000 fffff 00 1 00000008 b08 d08 0 07030100 00000000
rd_upper_neg 0e 0c 00 00 00 00 00 00 05 00000000 fffff 00 1 00000d08 b08 d08 0 07030100 00000000
hk_version 02 00 00 00 00 00 00 00 05 00000000 fffff 00 1 0000001a b08 d08 0 07030100 00000000
rd_version 0e 03 00 00 00 00 00 00 05 00000000 fffff 00 1 0000001a b08 d08 0 07030100 00000000
fan_on 02 06 01 00 00 00 00 00 05 00000000 fffff 00 1 00000000 b08 d08 0 07030100 00000001
fan_off 02 06 00 00 00 00 00 00 05 00000000 fffff 00 1 00000001 b08 d08 0 07030100 00000000
prelen_a 02 07 00 01 00 00 00 00 05 00000000 fffff 00 1 00000000 b08 d08 0 07030100 00000000
prelen_b 02 07 34 12 00 00 00 00 05 00000000 fffff 00 1 00000100 b08 d08 0 07030100 00000000
roll_on 02 08 01 00 00 00 00 00 05 00000000 fffff 00 1 00000000 b08 d08 0 07030100 00000002
roll_again 02 08 01 00 00 00 00 00 05 00000000 fffff 00 1 00000001 b08 d08 0 07030100 00000002
hk_boardin 02 01 00 00 00 00 00 00 05 deadbeef fffff a5 1 000000a5 b08 d08 0 07030100 00000002
hk_evcnt 02 03 00 00 00 00 00 00 05 deadbeef fffff a5 1 deadbeef b08 d08 0 07030100 00000002
rd_boardin 0e 04 00 00 00 00 00 00 05 deadbeef fffff a5 1 000000a5 b08 d08 0 07030100 00000002
bout_3 0a 03 01 00 00 00 00 00 05 deadbeef fffff a5 1 00000008 b08 d08 0 07030100 08000002
bout_6 0a 06 01 00 00 00 00 00 05 deadbeef fffff a5 1 00000048 b08 d08 0 07030100 48000002
bout_clr3 0a 03 00 00 00 00 00 00 05 deadbeef fffff a5 1 00000040 b08 d08 0 07030100 40000002
ds_set 09 13 01 22 00 00 00 00 05 deadbeef fffff a5 1 00000009 b08 d08 0 07030100 40221306
rd_merge 0e 09 00 00 00 00 00 00 05 deadbeef fffff a5 1 00000022 b08 d08 0 07030100 40221306
rd_ds 0e 0a 00 00 00 00 00 00 05 deadbeef fffff a5 1 00000013 b08 d08 0 07030100 40221306
rd_highres 0e 0b 00 00 00 00 00 00 05 deadbeef fffff a5 1 00000001 b08 d08 0 07030100 40221306
unknown 05 0c 00 00 00 00 00 00 05 deadbeef fffff a5 0 00000000 b08 d08 0 07030100 40221306
after_unk 0e 03 00 00 00 00 00 00 05 deadbeef fffff a5 1 0000001a b08 d08 0 07030100 40221306
rd_acq 0e 05 00 00 00 00 00 00 05 deadbeef fffff a5 1 00000005 b08 d08 0 07030100 40221306
latency 02 00 00 00 00 00 00 00 05 deadbeef fffff a5 2 0000001a b08 d08 0 07030100 40221306

//--- command_processor.f
+incdir+rtl
rtl/cmd_pkg.sv
rtl/cmd_rx_assembler.sv
rtl/cmd_executor.sv
rtl/usb_resp_tx.sv
rtl/command_processor.sv
verif/tb_command_processor.sv

//--- Bender.yml
package:
  name: command_processor

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cmd_pkg.sv
      - rtl/cmd_rx_assembler.sv
      - rtl/cmd_executor.sv
      - rtl/usb_resp_tx.sv
      - rtl/command_processor.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_command_processor.sv
